// File: Bender.yml
package:
  name: rv_core

dependencies: {}

sources:
  # rtl
  - files:
      - hw/rv_pkg.sv
      - hw/rv_core_if.sv
      - hw/rv_decode.sv
      - hw/rv_regfile.sv
      - hw/rv_execute.sv
      - hw/rv_result.sv
      - hw/rv_core.sv
  # verif
  - target: test
    files:
      - verif/tb_rv_core.sv

// File: files.f
hw/rv_pkg.sv
hw/rv_core_if.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core.sv
verif/tb_rv_core.sv

// File: hw/rv_core.sv
// RV64I single-cycle core
`timescale 1ns/1ns

module rv_core import rv_pkg::*; #(
  parameter xlen_t reset_pc = 64'h8000_0000
) (
  input  logic     clk,
  input  logic     rst,
  input  inst_t    inst,
  input  logic     inst_valid,
  output xlen_t    pc,
  output logic     wb_valid,
  output reg_idx_t wb_rd,
  output xlen_t    wb_data,
  output logic     halted
);

  reg_idx_t rs1_addr;
  reg_idx_t rs2_addr;
  xlen_t    rs1_data;
  xlen_t    rs2_data;
  logic     wr_en;
  reg_idx_t wr_addr;
  xlen_t    wr_data;

  dec_exe_if dec_exe ();
  exe_res_if exe_res ();

  rv_decode rv_decode_inst (
    .inst     (inst),
    .pc       (pc),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .de       (dec_exe.dec)
  );

  rv_regfile rv_regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  rv_execute rv_execute_inst (
    .pc (pc),
    .de (dec_exe.exe),
    .er (exe_res.exe)
  );

  rv_result #(
    .reset_pc (reset_pc)
  ) rv_result_inst (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .er         (exe_res.res),
    .pc         (pc),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .halted     (halted)
  );

endmodule

// File: hw/rv_core_if.sv
// core stage interfaces
`timescale 1ns/1ns

// decoded instruction with its operands
interface dec_exe_if import rv_pkg::*; ();

  op_t         op;
  reg_idx_t    rd;
  xlen_t       rs1_val;  // operand a, may be pc or zero
  xlen_t       rs2_val;
  xlen_t       imm;      // sign-extended to 64 bits
  logic [5:0]  shamt;

  modport dec (
    output op,
    output rd,
    output rs1_val,
    output rs2_val,
    output imm,
    output shamt
  );

  modport exe (
    input op,
    input rd,
    input rs1_val,
    input rs2_val,
    input imm,
    input shamt
  );

endinterface

// execute results toward retirement
interface exe_res_if import rv_pkg::*; ();

  logic     wr_en;    // writes rd and rd is not x0
  reg_idx_t rd;
  xlen_t    wr_data;
  xlen_t    next_pc;
  logic     halt_req;

  modport exe (
    output wr_en,
    output rd,
    output wr_data,
    output next_pc,
    output halt_req
  );

  modport res (
    input wr_en,
    input rd,
    input wr_data,
    input next_pc,
    input halt_req
  );

endinterface

// File: hw/rv_decode.sv
// RV64I instruction decode
`timescale 1ns/1ns

module rv_decode import rv_pkg::*; (
  input  inst_t    inst,
  input  xlen_t    pc,
  output reg_idx_t rs1_addr,
  output reg_idx_t rs2_addr,
  input  xlen_t    rs1_data,
  input  xlen_t    rs2_data,
  dec_exe_if.dec   de
);

  // major opcodes
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;

  localparam inst_t EBREAK_WORD = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  op_t        op;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign de.rd    = inst[11:7];
  assign de.shamt = inst[25:20]; // 6 bits for rv64

  // all formats sign-extend from bit 31
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // pick the immediate by instruction format
  always_comb begin
    case (opcode)
      OPC_OP_IMM, OPC_OP_IMM_32, OPC_JALR: de.imm = imm_i;
      OPC_STORE:                           de.imm = imm_s;
      OPC_BRANCH:                          de.imm = imm_b;
      OPC_LUI, OPC_AUIPC:                  de.imm = imm_u;
      OPC_JAL:                             de.imm = imm_j;
      default:                             de.imm = '0;
    endcase
  end

  // operation lookup, unknown encodings stay nop
  always_comb begin
    op = OP_NOP;
    if (inst == EBREAK_WORD) begin
      op = OP_EBREAK;
    end else begin
      case (opcode)
        OPC_OP: begin
          if (funct3 == 3'b000 && funct7 == 7'b0000000) op = OP_ADD;
          if (funct3 == 3'b000 && funct7 == 7'b0100000) op = OP_SUB;
        end
        OPC_OP_32: begin
          if (funct3 == 3'b000 && funct7 == 7'b0000000) op = OP_ADDW;
        end
        OPC_OP_IMM: begin
          case (funct3)
            3'b000: op = OP_ADDI;
            3'b011: op = OP_SLTIU;
            3'b101: if (inst[31:26] == 6'b010000) op = OP_SRAI; // funct6 only
            default: op = OP_NOP;
          endcase
        end
        OPC_OP_IMM_32: if (funct3 == 3'b000) op = OP_ADDIW;
        OPC_LUI:       op = OP_LUI;
        OPC_AUIPC:     op = OP_AUIPC;
        OPC_JAL:       op = OP_JAL;
        OPC_JALR:      if (funct3 == 3'b000) op = OP_JALR;
        OPC_BRANCH:    if (funct3 == 3'b001) op = OP_BNE;
        default:       op = OP_NOP;
      endcase
    end
  end

  assign de.op = op;

  // operand a select lets lui and auipc share the immediate adder
  always_comb begin
    case (op)
      OP_AUIPC: de.rs1_val = pc;
      OP_LUI:   de.rs1_val = '0;
      default:  de.rs1_val = rs1_data;
    endcase
  end

  assign de.rs2_val = rs2_data;

endmodule

// File: hw/rv_execute.sv
// RV64I execute stage
`timescale 1ns/1ns

module rv_execute import rv_pkg::*; (
  input  xlen_t  pc,
  dec_exe_if.exe de,
  exe_res_if.exe er
);

  xlen_t       pc_plus4;
  xlen_t       sum_rr;
  xlen_t       diff_rr;
  xlen_t       sum_ri;      // also serves lui and auipc
  xlen_t       w_addend;
  logic [31:0] sum_w;
  xlen_t       br_target;
  xlen_t       jalr_target;
  xlen_t       result;
  logic        writes_rd;
  logic        taken;

  assign pc_plus4    = pc + 64'd4;
  assign sum_rr      = de.rs1_val + de.rs2_val;
  assign diff_rr     = de.rs1_val - de.rs2_val;
  assign sum_ri      = de.rs1_val + de.imm;
  assign w_addend    = (de.op == OP_ADDW) ? de.rs2_val : de.imm;
  assign sum_w       = de.rs1_val[31:0] + w_addend[31:0]; // word ops wrap at 32 bits
  assign br_target   = pc + de.imm;
  assign jalr_target = {sum_ri[63:1], 1'b0};

  always_comb begin
    case (de.op)
      OP_ADD:              result = sum_rr;
      OP_SUB:              result = diff_rr;
      OP_ADDW, OP_ADDIW:   result = {{32{sum_w[31]}}, sum_w};
      OP_ADDI:             result = sum_ri;
      OP_SLTIU:            result = {63'b0, de.rs1_val < de.imm};
      OP_SRAI:             result = $signed(de.rs1_val) >>> de.shamt;
      OP_LUI, OP_AUIPC:    result = sum_ri; // operand a is 0 or pc
      OP_JAL, OP_JALR:     result = pc_plus4; // link value
      default:             result = '0;
    endcase
  end

  assign taken = (de.op == OP_BNE) && (de.rs1_val != de.rs2_val);

  always_comb begin
    if (de.op == OP_JAL || taken) begin
      er.next_pc = br_target;
    end else if (de.op == OP_JALR) begin
      er.next_pc = jalr_target;
    end else begin
      er.next_pc = pc_plus4;
    end
  end

  // nop, bne and ebreak leave rd alone
  assign writes_rd = !(de.op == OP_NOP || de.op == OP_BNE || de.op == OP_EBREAK);

  assign er.wr_en    = writes_rd && (de.rd != '0);
  assign er.rd       = de.rd;
  assign er.wr_data  = result;
  assign er.halt_req = (de.op == OP_EBREAK);

endmodule

// File: hw/rv_pkg.sv
// RV64I core shared types
package rv_pkg;

  typedef logic [63:0] xlen_t;    // register or pc value
  typedef logic [31:0] inst_t;    // raw instruction word
  typedef logic [4:0]  reg_idx_t; // register index
  typedef logic [4:0]  op_t;      // decoded operation

  // operation codes carried from decode to execute
  localparam op_t OP_NOP    = 5'd0;
  localparam op_t OP_ADD    = 5'd1;
  localparam op_t OP_SUB    = 5'd2;
  localparam op_t OP_ADDW   = 5'd3;
  localparam op_t OP_ADDI   = 5'd4;
  localparam op_t OP_ADDIW  = 5'd5;
  localparam op_t OP_SLTIU  = 5'd6;
  localparam op_t OP_SRAI   = 5'd7;
  localparam op_t OP_LUI    = 5'd8;
  localparam op_t OP_AUIPC  = 5'd9;
  localparam op_t OP_JAL    = 5'd10;
  localparam op_t OP_JALR   = 5'd11;
  localparam op_t OP_BNE    = 5'd12;
  localparam op_t OP_EBREAK = 5'd13;

endpackage

// File: hw/rv_regfile.sv
// integer register file
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1_addr,
  input  reg_idx_t rs2_addr,
  output xlen_t    rs1_data,
  output xlen_t    rs2_data,
  input  logic     wr_en,
  input  reg_idx_t wr_addr,
  input  xlen_t    wr_data
);

  xlen_t regs [1:31]; // x0 has no storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // asynchronous reads
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: hw/rv_result.sv
// retirement and writeback report
`timescale 1ns/1ns

module rv_result import rv_pkg::*; #(
  parameter xlen_t reset_pc = 64'h8000_0000
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     inst_valid,
  exe_res_if.res   er,
  output xlen_t    pc,
  output logic     wr_en,
  output reg_idx_t wr_addr,
  output xlen_t    wr_data,
  output logic     wb_valid,
  output reg_idx_t wb_rd,
  output xlen_t    wb_data,
  output logic     halted
);

  logic retire;

  assign retire = inst_valid && !halted; // ignored once halted

  // register file write in the retiring cycle
  assign wr_en   = retire && er.wr_en;
  assign wr_addr = er.rd;
  assign wr_data = er.wr_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc       <= reset_pc;
      wb_valid <= 1'b0;
      halted   <= 1'b0;
    end else begin
      wb_valid <= wr_en; // one-cycle pulse
      if (retire) begin
        pc <= er.next_pc;
        if (er.halt_req) halted <= 1'b1;
      end
    end
  end

  // report payload, only meaningful with wb_valid
  always_ff @(posedge clk) begin
    if (wr_en) begin
      wb_rd   <= er.rd;
      wb_data <= er.wr_data;
    end
  end

endmodule

// File: verif/tb_rv_core.sv
// RV64I core testbench
`timescale 1ns/1ns

module tb_rv_core;

  localparam int MAX_ENTRIES  = 32;
  localparam int HALT_TIMEOUT = 20; // cycles

  logic        clk;
  logic        rst;
  logic [31:0] inst;
  logic        inst_valid;
  logic [63:0] pc;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [63:0] wb_data;
  logic        halted;

  // stimulus and expected values per instruction
  string       t_name     [MAX_ENTRIES];
  logic [31:0] t_inst     [MAX_ENTRIES];
  logic        t_wb_valid [MAX_ENTRIES];
  logic [4:0]  t_wb_rd    [MAX_ENTRIES];
  logic [63:0] t_wb_data  [MAX_ENTRIES];
  logic [63:0] t_pc       [MAX_ENTRIES];
  logic        t_halted   [MAX_ENTRIES];
  int          num_entries;

  int errors;
  int tests_passed;
  int tests_failed;

  rv_core rv_core_inst (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .inst_valid (inst_valid),
    .pc         (pc),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .halted     (halted)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  task automatic check_value(input string test_name, input string field,
                             input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Error %s %s: expected %h, actual %h", test_name, field, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input string test_name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("pass %s", test_name);
    end else begin
      tests_failed++;
      $display("fail %s", test_name);
    end
  endtask

  task add_entry(input string name, input logic [31:0] word, input logic exp_wb_valid,
                 input logic [4:0] exp_rd, input logic [63:0] exp_data,
                 input logic [63:0] exp_pc, input logic exp_halted);
    t_name[num_entries]     = name;
    t_inst[num_entries]     = word;
    t_wb_valid[num_entries] = exp_wb_valid;
    t_wb_rd[num_entries]    = exp_rd;
    t_wb_data[num_entries]  = exp_data;
    t_pc[num_entries]       = exp_pc;
    t_halted[num_entries]   = exp_halted;
    num_entries++;
  endtask

  task load_table();
    num_entries = 0;
    add_entry("addi_neg", 32'hFFB0_0093,
              1'b1, 5'd1, 64'hFFFF_FFFF_FFFF_FFFB, 64'h8000_0004, 1'b0);
    add_entry("addi_pos", 32'h0640_0113,
              1'b1, 5'd2, 64'h0000_0000_0000_0064, 64'h8000_0008, 1'b0);
    add_entry("add", 32'h0020_81B3,
              1'b1, 5'd3, 64'h0000_0000_0000_005F, 64'h8000_000C, 1'b0);
    add_entry("sub", 32'h4020_8233,
              1'b1, 5'd4, 64'hFFFF_FFFF_FFFF_FF97, 64'h8000_0010, 1'b0);
    add_entry("lui_neg", 32'h8000_02B7,
              1'b1, 5'd5, 64'hFFFF_FFFF_8000_0000, 64'h8000_0014, 1'b0);
    add_entry("addiw_wrap", 32'hFFF2_831B, // 0x80000000 - 1 wraps positive
              1'b1, 5'd6, 64'h0000_0000_7FFF_FFFF, 64'h8000_0018, 1'b0);
    add_entry("addw_wrap", 32'h0063_03BB,
              1'b1, 5'd7, 64'hFFFF_FFFF_FFFF_FFFE, 64'h8000_001C, 1'b0);
    add_entry("sltiu_huge", 32'hFFF1_3413, // imm -1 compares as all ones
              1'b1, 5'd8, 64'h0000_0000_0000_0001, 64'h8000_0020, 1'b0);
    add_entry("sltiu_false", 32'h0321_3493,
              1'b1, 5'd9, 64'h0000_0000_0000_0000, 64'h8000_0024, 1'b0);
    add_entry("srai_neg", 32'h4042_5513,
              1'b1, 5'd10, 64'hFFFF_FFFF_FFFF_FFF9, 64'h8000_0028, 1'b0);
    add_entry("auipc", 32'h0000_1597,
              1'b1, 5'd11, 64'h0000_0000_8000_1028, 64'h8000_002C, 1'b0);
    add_entry("jal", 32'h0100_066F,
              1'b1, 5'd12, 64'h0000_0000_8000_0030, 64'h8000_003C, 1'b0);
    add_entry("jalr_odd", 32'h0055_86E7, // target bit 0 dropped
              1'b1, 5'd13, 64'h0000_0000_8000_0040, 64'h8000_102C, 1'b0);
    add_entry("bne_taken", 32'h0020_9463,
              1'b0, 5'd0, 64'h0, 64'h8000_1034, 1'b0);
    add_entry("bne_not_taken", 32'h0021_1463,
              1'b0, 5'd0, 64'h0, 64'h8000_1038, 1'b0);
    add_entry("write_x0", 32'h0070_8013,
              1'b0, 5'd0, 64'h0, 64'h8000_103C, 1'b0);
    add_entry("unknown_lw", 32'h0000_2083,
              1'b0, 5'd0, 64'h0, 64'h8000_1040, 1'b0);
    add_entry("x1_kept", 32'h0000_8733, // lw must not have touched x1
              1'b1, 5'd14, 64'hFFFF_FFFF_FFFF_FFFB, 64'h8000_1044, 1'b0);
    add_entry("addi_neg_neg", 32'hFFD0_8793,
              1'b1, 5'd15, 64'hFFFF_FFFF_FFFF_FFF8, 64'h8000_1048, 1'b0);
    add_entry("ebreak", 32'h0010_0073,
              1'b0, 5'd0, 64'h0, 64'h8000_104C, 1'b1);
    add_entry("halted_addi", 32'h0010_0793,
              1'b0, 5'd0, 64'h0, 64'h8000_104C, 1'b1);
    add_entry("halted_jal", 32'h0100_00EF,
              1'b0, 5'd0, 64'h0, 64'h8000_104C, 1'b1);
  endtask

  task automatic wait_for_halted(output logic timed_out);
    int cycles;
    cycles = 0;
    while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    timed_out = (halted !== 1'b1);
  endtask

  initial begin
    int   errors_before;
    logic timed_out;
    rst          = 1'b1;
    inst         = '0;
    inst_valid   = 1'b0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    load_table();

    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;

    errors_before = errors;
    check_value("reset", "pc", 64'h8000_0000, pc);
    check_value("reset", "wb_valid", 64'd0, {63'd0, wb_valid});
    check_value("reset", "halted", 64'd0, {63'd0, halted});
    report_test("reset", errors_before);

    // rows run back to back and each is checked one cycle later
    for (int i = 0; i < num_entries; i++) begin
      inst       = t_inst[i];
      inst_valid = 1'b1;
      @(posedge clk);
      #2;
      errors_before = errors;
      check_value(t_name[i], "wb_valid", {63'd0, t_wb_valid[i]}, {63'd0, wb_valid});
      if (t_wb_valid[i]) begin
        check_value(t_name[i], "wb_rd", {59'd0, t_wb_rd[i]}, {59'd0, wb_rd});
        check_value(t_name[i], "wb_data", t_wb_data[i], wb_data);
      end
      check_value(t_name[i], "pc", t_pc[i], pc);
      check_value(t_name[i], "halted", {63'd0, t_halted[i]}, {63'd0, halted});
      report_test(t_name[i], errors_before);
    end
    inst_valid = 1'b0;

    // a reset clears the halt and a fresh ebreak sets it again
    rst = 1'b1;
    @(posedge clk);
    #2;
    rst           = 1'b0;
    inst          = 32'h0010_0073;
    inst_valid    = 1'b1;
    errors_before = errors;
    check_value("halt_after_reset", "halted", 64'd0, {63'd0, halted});
    check_value("halt_after_reset", "pc", 64'h8000_0000, pc);
    wait_for_halted(timed_out);
    inst_valid = 1'b0;
    if (timed_out) begin
      $display("halted did not rise within %0d cycles after ebreak", HALT_TIMEOUT);
      errors++;
    end
    check_value("halt_after_reset", "pc", 64'h8000_0004, pc);
    report_test("halt_after_reset", errors_before);

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
